//--- rtl/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int XLEN    = 32; // RV32I register width
    localparam int SHAMT_W = 5;  // shift amount field width

    // major opcodes handled by the execute stage
    localparam logic [6:0] OPC_OP     = 7'b0110011; // R-type register ops
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // I-type immediate ops
    localparam logic [6:0] OPC_BRANCH = 7'b1100011; // conditional branches

    // funct3 for OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3 for BRANCH, 3'b010 and 3'b011 are reserved
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_BLT     = 3'b100;
    localparam logic [2:0] F3_BGE     = 3'b101;
    localparam logic [2:0] F3_BLTU    = 3'b110;
    localparam logic [2:0] F3_BGEU    = 3'b111;

    // funct7, the alternate form selects SUB and SRA
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;

    // operation selected by decode and evaluated by the ALU
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3,
        SLTU = 4'd4,
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        OR   = 4'd8,
        AND  = 4'd9,
        BEQ  = 4'd10,
        BNE  = 4'd11,
        BLT  = 4'd12,
        BGE  = 4'd13,
        BLTU = 4'd14,
        BGEU = 4'd15
    } operation_t;

endpackage

//--- rtl/ex_types_pkg.sv
package ex_types_pkg;

    // instruction as handed over by the decode/issue side
    typedef struct packed {
        logic [6:0]                    opcode;
        logic [2:0]                    funct3;
        logic [6:0]                    funct7;  // holds imm[11:5] for OP-IMM
        logic [rv_isa_pkg::XLEN-1:0]   rs1_val;
        logic [rv_isa_pkg::XLEN-1:0]   rs2_val;
        logic [rv_isa_pkg::XLEN-1:0]   imm;     // already sign extended
        logic [rv_isa_pkg::XLEN-1:0]   pc;
        logic [4:0]                    rd;
    } ex_req_t;

    // decoded instruction held in the decode register
    typedef struct packed {
        rv_isa_pkg::operation_t        op;
        logic                          is_branch;
        logic                          writes_rd;
        logic                          illegal;
        logic [rv_isa_pkg::XLEN-1:0]   op_a;
        logic [rv_isa_pkg::XLEN-1:0]   op_b;       // rs2 or immediate
        logic [rv_isa_pkg::XLEN-1:0]   branch_ofs; // zero unless branch
        logic [rv_isa_pkg::XLEN-1:0]   pc;
        logic [4:0]                    rd;
    } alu_ctrl_t;

    // combinational ALU output
    typedef struct packed {
        logic [rv_isa_pkg::XLEN-1:0]   result;
        logic                          zero;
        logic                          cond_taken; // branch condition met
    } alu_out_t;

    // registered result of the execute stage
    typedef struct packed {
        logic                          rd_we;
        logic [4:0]                    rd;
        logic [rv_isa_pkg::XLEN-1:0]   wb_data;
        logic                          zero;
        logic                          branch_taken;
        logic [rv_isa_pkg::XLEN-1:0]   branch_target;
        logic                          illegal;
    } ex_resp_t;

endpackage

//--- rtl/alu_control_unit.sv
`timescale 1ns/1ps

module alu_control_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  ex_types_pkg::ex_req_t   in_req,
    output logic                    ctrl_valid,
    output ex_types_pkg::alu_ctrl_t ctrl
);
    import rv_isa_pkg::*;
    import ex_types_pkg::*;

    operation_t op_dec;
    logic       illegal_dec;
    logic       is_op;
    logic       is_op_imm;
    logic       is_branch;
    alu_ctrl_t  ctrl_next;

    // base-form operation for a funct3 of OP / OP-IMM
    function automatic operation_t base_op(input logic [2:0] funct3);
        case (funct3)
            F3_ADD_SUB: return ADD;
            F3_SLL:     return SLL;
            F3_SLT:     return SLT;
            F3_SLTU:    return SLTU;
            F3_XOR:     return XOR;
            F3_SRL_SRA: return SRL;
            F3_OR:      return OR;
            default:    return AND;
        endcase
    endfunction

    assign is_op     = (in_req.opcode == OPC_OP);
    assign is_op_imm = (in_req.opcode == OPC_OP_IMM);
    assign is_branch = (in_req.opcode == OPC_BRANCH);

    always_comb
    begin
        op_dec      = ADD;
        illegal_dec = 1'b0;
        case (in_req.opcode)
            OPC_OP:
            begin
                if (in_req.funct7 == F7_BASE)
                    op_dec = base_op(in_req.funct3);
                else if (in_req.funct7 == F7_ALT)
                begin
                    case (in_req.funct3)
                        F3_ADD_SUB: op_dec = SUB;
                        F3_SRL_SRA: op_dec = SRA;
                        default:    illegal_dec = 1'b1; // no alternate form
                    endcase
                end
                else
                    illegal_dec = 1'b1;
            end
            OPC_OP_IMM:
            begin
                // funct7 only matters for the shifts, there is no SUBI
                case (in_req.funct3)
                    F3_SLL:
                    begin
                        op_dec      = SLL;
                        illegal_dec = (in_req.funct7 != F7_BASE);
                    end
                    F3_SRL_SRA:
                    begin
                        if (in_req.funct7 == F7_BASE)
                            op_dec = SRL;
                        else if (in_req.funct7 == F7_ALT)
                            op_dec = SRA;
                        else
                            illegal_dec = 1'b1;
                    end
                    default: op_dec = base_op(in_req.funct3);
                endcase
            end
            OPC_BRANCH:
            begin
                case (in_req.funct3)
                    F3_BEQ:  op_dec = BEQ;
                    F3_BNE:  op_dec = BNE;
                    F3_BLT:  op_dec = BLT;
                    F3_BGE:  op_dec = BGE;
                    F3_BLTU: op_dec = BLTU;
                    F3_BGEU: op_dec = BGEU;
                    default: illegal_dec = 1'b1; // reserved funct3
                endcase
            end
            default: illegal_dec = 1'b1; // opcode not handled here
        endcase
        if (illegal_dec)
            op_dec = ADD;
    end

    always_comb
    begin
        ctrl_next.op         = op_dec;
        ctrl_next.is_branch  = is_branch;
        ctrl_next.writes_rd  = is_op | is_op_imm;
        ctrl_next.illegal    = illegal_dec;
        ctrl_next.op_a       = in_req.rs1_val;
        ctrl_next.op_b       = is_op_imm ? in_req.imm : in_req.rs2_val; // shamt in imm[4:0]
        ctrl_next.branch_ofs = is_branch ? in_req.imm : '0;
        ctrl_next.pc         = in_req.pc;
        ctrl_next.rd         = in_req.rd;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            ctrl_valid <= 1'b0;
        else
            ctrl_valid <= in_valid;
    end

    always_ff @(posedge clk)
    begin
        if (in_valid)
            ctrl <= ctrl_next; // holds last instruction between strobes
    end

endmodule

//--- rtl/alu.sv
`timescale 1ns/1ps

module alu (
    input  ex_types_pkg::alu_ctrl_t ctrl,
    output ex_types_pkg::alu_out_t  alu_res
);
    import rv_isa_pkg::*;

    logic signed [XLEN-1:0] op_a_s;
    logic signed [XLEN-1:0] op_b_s;
    logic [SHAMT_W-1:0]     shamt;
    logic [XLEN-1:0]        result;
    logic                   cond;

    assign op_a_s = ctrl.op_a;
    assign op_b_s = ctrl.op_b;
    assign shamt  = ctrl.op_b[SHAMT_W-1:0]; // low bits of rs2 or immediate

    always_comb
    begin
        result = '0; // branches leave the result at zero
        cond   = 1'b0;
        case (ctrl.op)
            ADD:
                result = ctrl.op_a + ctrl.op_b; // carry out dropped
            SUB:
                result = ctrl.op_a - ctrl.op_b;
            SLL:
                result = ctrl.op_a << shamt;
            SLT:
                result = {{(XLEN-1){1'b0}}, (op_a_s < op_b_s)};
            SLTU:
                result = {{(XLEN-1){1'b0}}, (ctrl.op_a < ctrl.op_b)};
            XOR:
                result = ctrl.op_a ^ ctrl.op_b;
            SRL:
                result = ctrl.op_a >> shamt;
            SRA:
                result = $unsigned(op_a_s >>> shamt); // sign fill from bit 31
            OR:
                result = ctrl.op_a | ctrl.op_b;
            AND:
                result = ctrl.op_a & ctrl.op_b;

            BEQ:
                cond = (ctrl.op_a == ctrl.op_b);
            BNE:
                cond = (ctrl.op_a != ctrl.op_b);
            BLT:
                cond = (op_a_s < op_b_s);
            BGE:
                cond = (op_a_s >= op_b_s);
            BLTU:
                cond = (ctrl.op_a < ctrl.op_b);
            BGEU:
                cond = (ctrl.op_a >= ctrl.op_b);

            default:
            begin
                result = '0;
                cond   = 1'b0;
            end
        endcase
    end

    assign alu_res.result     = result;
    assign alu_res.zero       = ~|result;
    assign alu_res.cond_taken = cond;

endmodule

//--- rtl/ex_result_stage.sv
`timescale 1ns/1ps

module ex_result_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    ctrl_valid,
    input  ex_types_pkg::alu_ctrl_t ctrl,
    input  ex_types_pkg::alu_out_t  alu_res,
    output logic                    out_valid,
    output ex_types_pkg::ex_resp_t  out_resp
);
    import ex_types_pkg::*;

    logic     legal_alu;
    logic     legal_branch;
    ex_resp_t resp_next;

    // ctrl holds stale data between strobes, so everything is qualified by valid
    assign legal_alu    = ctrl_valid & ctrl.writes_rd & ~ctrl.illegal;
    assign legal_branch = ctrl_valid & ctrl.is_branch & ~ctrl.illegal;

    always_comb
    begin
        resp_next.rd_we         = legal_alu;
        resp_next.rd            = ctrl.rd;
        resp_next.wb_data       = legal_alu ? alu_res.result : '0;
        resp_next.zero          = legal_alu ? alu_res.zero : 1'b1; // wb_data is zero
        resp_next.branch_taken  = legal_branch & alu_res.cond_taken;
        resp_next.branch_target = legal_branch ? (ctrl.pc + ctrl.branch_ofs) : '0;
        resp_next.illegal       = ctrl_valid & ctrl.illegal;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            out_valid             <= 1'b0;
            out_resp.rd_we        <= 1'b0;
            out_resp.branch_taken <= 1'b0;
            out_resp.illegal      <= 1'b0;
        end
        else
        begin
            out_valid <= ctrl_valid;
            out_resp  <= resp_next;  // one-cycle pulse, no stall
        end
    end

endmodule

//--- rtl/rv_execute_unit.sv
`timescale 1ns/1ps

module rv_execute_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  ex_types_pkg::ex_req_t  in_req,
    output logic                   out_valid,
    output ex_types_pkg::ex_resp_t out_resp
);
    import ex_types_pkg::*;

    logic      ctrl_valid;
    alu_ctrl_t ctrl;
    alu_out_t  alu_res;

    // decode register, first pipeline stage
    alu_control_unit u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .ctrl_valid (ctrl_valid),
        .ctrl       (ctrl)
    );

    alu u_alu (
        .ctrl    (ctrl),
        .alu_res (alu_res)
    );

    // output register, second pipeline stage
    ex_result_stage u_result (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl_valid (ctrl_valid),
        .ctrl       (ctrl),
        .alu_res    (alu_res),
        .out_valid  (out_valid),
        .out_resp   (out_resp)
    );

endmodule

//--- verification/rv_execute_checker.sv
`timescale 1ns/1ps

module rv_execute_checker (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   in_valid,
    input logic                   out_valid,
    input ex_types_pkg::ex_resp_t out_resp
);
    int unsigned fail_count = 0;
    logic        started = 1'b0; // masks the first edge, before any history

    always @(posedge clk)
        started <= 1'b1;

    // decode register then result register
    a_latency: assert property (@(posedge clk)
        (started && $past(rst_n, 1) && $past(rst_n, 2)) |-> (out_valid == $past(in_valid, 2)))
    else
    begin
        $error("out_valid does not follow in_valid by two cycles");
        fail_count++;
    end

    a_illegal_masks: assert property (@(posedge clk)
        (started && out_valid && out_resp.illegal) |->
        (!out_resp.rd_we && !out_resp.branch_taken))
    else
    begin
        $error("illegal result with rd_we or branch_taken set");
        fail_count++;
    end

    a_branch_no_wb: assert property (@(posedge clk)
        (started && out_valid && out_resp.branch_taken) |-> !out_resp.rd_we)
    else
    begin
        $error("taken branch also writes rd");
        fail_count++;
    end

    a_reset_clears: assert property (@(posedge clk)
        (started && !$past(rst_n)) |->
        !(out_valid || out_resp.rd_we || out_resp.branch_taken || out_resp.illegal))
    else
    begin
        $error("control outputs not low after reset");
        fail_count++;
    end

endmodule

bind rv_execute_unit rv_execute_checker u_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .out_resp  (out_resp)
);

//--- verification/tb_rv_execute_unit.sv
`timescale 1ns/1ps

module tb_rv_execute_unit;
    import rv_isa_pkg::*;
    import ex_types_pkg::*;

    localparam int RESET_CYCLES   = 3;
    localparam int ISSUE_CYCLES   = 2000;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + ISSUE_CYCLES + 20;
    localparam int MID_RESET_AT   = 1200; // reset hits with instructions in flight

    typedef struct packed {
        ex_resp_t resp;
        int       due; // cycle at which the result must show up
    } pending_t;

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    ex_req_t  in_req;
    logic     out_valid;
    ex_resp_t out_resp;

    pending_t exp_q[$];
    integer   seed;
    int       cyc = 0;
    int       value_errors = 0;
    int       protocol_errors = 0;
    int       checked = 0;

    rv_execute_unit u_rv_execute_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_resp  (out_resp)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
        cyc <= cyc + 1;

    task automatic print_counts();
        $display("checked %0d results: %0d value errors, %0d protocol errors, %0d assertion failures",
                 checked, value_errors, protocol_errors, u_rv_execute_unit.u_checker.fail_count);
    endtask

    initial
    begin
        while (cyc < TIMEOUT_CYCLES)
            @(posedge clk);
        $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        print_counts();
        $display("RESULT: FAIL");
        $finish;
    end

    // expected response, straight from the encoding rules
    function automatic ex_resp_t model_response(input ex_req_t req);
        ex_resp_t    resp;
        logic [31:0] a;
        logic [31:0] b;
        logic        alt;
        logic        bad;
        resp    = '0;
        resp.rd = req.rd;
        a       = req.rs1_val;
        b       = (req.opcode == OPC_OP_IMM) ? req.imm : req.rs2_val;
        alt     = (req.funct7 == F7_ALT);
        case (req.opcode)
            OPC_OP:
                bad = !(req.funct7 == F7_BASE ||
                        (alt && (req.funct3 == F3_ADD_SUB || req.funct3 == F3_SRL_SRA)));
            OPC_OP_IMM:
                bad = (req.funct3 == F3_SLL && req.funct7 != F7_BASE) ||
                      (req.funct3 == F3_SRL_SRA && req.funct7 != F7_BASE && !alt);
            OPC_BRANCH:
                bad = (req.funct3 == 3'b010 || req.funct3 == 3'b011);
            default:
                bad = 1'b1;
        endcase
        if (bad)
            resp.illegal = 1'b1;
        else if (req.opcode == OPC_BRANCH)
        begin
            case (req.funct3)
                F3_BEQ:  resp.branch_taken = (a == b);
                F3_BNE:  resp.branch_taken = (a != b);
                F3_BLT:  resp.branch_taken = ($signed(a) < $signed(b));
                F3_BGE:  resp.branch_taken = ($signed(a) >= $signed(b));
                F3_BLTU: resp.branch_taken = (a < b);
                default: resp.branch_taken = (a >= b);
            endcase
            resp.branch_target = req.pc + req.imm;
        end
        else
        begin
            resp.rd_we = 1'b1;
            case (req.funct3)
                F3_ADD_SUB: resp.wb_data = (alt && req.opcode == OPC_OP) ? a - b : a + b;
                F3_SLL:     resp.wb_data = a << b[4:0];
                F3_SLT:     resp.wb_data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                F3_SLTU:    resp.wb_data = (a < b) ? 32'd1 : 32'd0;
                F3_XOR:     resp.wb_data = a ^ b;
                F3_SRL_SRA:
                    if (alt)
                        resp.wb_data = $signed(a) >>> b[4:0]; // sign fill
                    else
                        resp.wb_data = a >> b[4:0];
                F3_OR:      resp.wb_data = a | b;
                default:    resp.wb_data = a & b;
            endcase
        end
        resp.zero = (resp.wb_data == 32'd0);
        return resp;
    endfunction

    task automatic pick_operand(output logic [31:0] val);
        logic [31:0] r;
        r = $random(seed);
        case (r[2:0])
            3'd0:    val = 32'h0;
            3'd1:    val = 32'hffffffff;
            3'd2:    val = 32'h80000000;
            3'd3:    val = 32'h7fffffff;
            default: val = $random(seed);
        endcase
    endtask

    task automatic make_request(output ex_req_t req);
        logic [31:0] r;
        logic [31:0] s;
        logic [31:0] t;
        logic [11:0] imm12;
        int          sel;
        r = $random(seed);
        s = $random(seed);
        t = $random(seed);
        sel = int'(r % 32'd100);
        pick_operand(req.rs1_val);
        pick_operand(req.rs2_val);
        if (r[10:8] == 3'd0)
            req.rs2_val = req.rs1_val; // equal pair for compares
        req.rd     = r[15:11];
        req.pc     = $random(seed);
        req.pc     = req.pc & 32'hfffffffc;
        req.funct3 = s[14:12];
        req.funct7 = s[31:25];
        imm12      = s[11:0];
        if (sel < 35)
        begin
            req.opcode = OPC_OP;
            req.funct7 = (s[20] && (req.funct3 == F3_ADD_SUB || req.funct3 == F3_SRL_SRA)) ?
                         F7_ALT : F7_BASE;
        end
        else if (sel < 65)
        begin
            req.opcode = OPC_OP_IMM;
            if (req.funct3 == F3_SLL)
                imm12[11:5] = F7_BASE;
            else if (req.funct3 == F3_SRL_SRA)
                imm12[11:5] = s[20] ? F7_ALT : F7_BASE;
            req.funct7 = imm12[11:5];
        end
        else if (sel < 90)
        begin
            req.opcode = OPC_BRANCH;
            imm12[0]   = 1'b0;
            if (req.funct3 == 3'b010 || req.funct3 == 3'b011)
                req.funct3 = {1'b1, req.funct3[1:0]}; // remap reserved codes
        end
        else
        begin
            case (t % 32'd6)
                0:
                begin
                    req.opcode = t[31:25];
                    if (req.opcode == OPC_OP || req.opcode == OPC_OP_IMM ||
                        req.opcode == OPC_BRANCH)
                        req.opcode = 7'b1111111;
                end
                1:
                begin
                    req.opcode = OPC_OP;
                    req.funct7 = t[22:16];
                    if (req.funct7 == F7_BASE || req.funct7 == F7_ALT)
                        req.funct7 = 7'b0000001;
                end
                2:
                begin
                    req.opcode = OPC_OP;
                    req.funct7 = F7_ALT;
                    if (req.funct3 == F3_ADD_SUB || req.funct3 == F3_SRL_SRA)
                        req.funct3 = F3_XOR; // alt form only on ADD and SRL
                end
                3:
                begin
                    req.opcode  = OPC_OP_IMM;
                    req.funct3  = F3_SLL;
                    imm12[11:5] = t[22:16] | 7'b0000001;
                    req.funct7  = imm12[11:5];
                end
                4:
                begin
                    req.opcode  = OPC_OP_IMM;
                    req.funct3  = F3_SRL_SRA;
                    imm12[11:5] = t[22:16];
                    if (imm12[11:5] == F7_BASE || imm12[11:5] == F7_ALT)
                        imm12[11:5] = 7'b1000001;
                    req.funct7  = imm12[11:5];
                end
                default:
                begin
                    req.opcode = OPC_BRANCH;
                    req.funct3 = {2'b01, t[0]};
                end
            endcase
        end
        req.imm = {{20{imm12[11]}}, imm12};
    endtask

    task automatic compare_field(input string name, input logic [31:0] want,
                                 input logic [31:0] got);
        assert (want === got)
        else
        begin
            $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, want, got);
            value_errors++;
        end
    endtask

    task automatic compare_resp(input ex_resp_t want);
        compare_field("out_resp.rd_we", 32'(want.rd_we), 32'(out_resp.rd_we));
        compare_field("out_resp.rd", 32'(want.rd), 32'(out_resp.rd));
        compare_field("out_resp.wb_data", want.wb_data, out_resp.wb_data);
        compare_field("out_resp.zero", 32'(want.zero), 32'(out_resp.zero));
        compare_field("out_resp.branch_taken", 32'(want.branch_taken),
                      32'(out_resp.branch_taken));
        compare_field("out_resp.branch_target", want.branch_target, out_resp.branch_target);
        compare_field("out_resp.illegal", 32'(want.illegal), 32'(out_resp.illegal));
    endtask

    // called at the falling edge, before new inputs are driven
    task automatic check_outputs();
        pending_t head;
        if (!rst_n)
        begin
            assert (!out_valid && !out_resp.rd_we && !out_resp.branch_taken && !out_resp.illegal)
            else
            begin
                $display("ERROR at %0t: outputs not cleared while reset is held", $time);
                protocol_errors++;
            end
        end
        else
        begin
            if (out_valid)
            begin
                assert (exp_q.size() > 0)
                else
                begin
                    $display("ERROR at %0t: out_valid with no instruction in flight", $time);
                    protocol_errors++;
                end
                if (exp_q.size() > 0)
                begin
                    head = exp_q.pop_front();
                    assert (head.due == cyc)
                    else
                    begin
                        $display("ERROR at %0t: result came at cycle %0d but was due at %0d",
                                 $time, cyc, head.due);
                        protocol_errors++;
                    end
                    compare_resp(head.resp);
                    checked++;
                end
            end
            if (exp_q.size() > 0)
            begin
                assert (exp_q[0].due > cyc)
                else
                begin
                    $display("ERROR at %0t: expected result missing at cycle %0d", $time, cyc);
                    protocol_errors++;
                    head = exp_q.pop_front();
                end
            end
        end
    endtask

    initial
    begin
        pending_t    entry;
        int          reset_left;
        logic [31:0] r;
        seed       = 32'h2fd8eb29;
        reset_left = 0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_req     = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        for (int i = 0; i < ISSUE_CYCLES; i++)
        begin
            @(negedge clk);
            check_outputs();
            if (i == MID_RESET_AT)
            begin
                reset_left = RESET_CYCLES;
                exp_q.delete(); // in-flight results are lost
            end
            r        = $random(seed);
            in_valid = (r[1:0] != 2'b00);
            make_request(in_req);
            if (reset_left > 0)
            begin
                rst_n = 1'b0;
                reset_left--;
            end
            else
            begin
                rst_n = 1'b1;
                if (in_valid)
                begin
                    entry.resp = model_response(in_req);
                    entry.due  = cyc + 2;
                    exp_q.push_back(entry);
                end
            end
        end
        while (exp_q.size() > 0)
        begin
            @(negedge clk);
            check_outputs();
            in_valid = 1'b0;
        end
        repeat (2)
        begin
            @(negedge clk);
            check_outputs(); // no stray pulses once drained
        end
        assert (checked > ISSUE_CYCLES / 2)
        else
        begin
            $display("ERROR: only %0d results were checked", checked);
            protocol_errors++;
        end
        print_counts();
        if (value_errors == 0 && protocol_errors == 0 &&
            u_rv_execute_unit.u_checker.fail_count == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- flist.f
rtl/rv_isa_pkg.sv
rtl/ex_types_pkg.sv
rtl/alu_control_unit.sv
rtl/alu.sv
rtl/ex_result_stage.sv
rtl/rv_execute_unit.sv
verification/rv_execute_checker.sv
verification/tb_rv_execute_unit.sv

//--- Makefile
SHELL := /bin/bash
TOP   := tb_rv_execute_unit

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module rv_execute_unit
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f flist.f --top-module $(TOP) -o sim_$(TOP)
	set -o pipefail; ./obj_dir/sim_$(TOP) 2>&1 | tee sim.log
	@if grep -q "RESULT: FAIL" sim.log; then echo "simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
